// File: filelist.f
hdl/dcache_pkg.sv
hdl/line_store.sv
hdl/miss_controller.sv
hdl/dcache_top.sv
tests/slow_mem_model.sv
tests/dcache_tb.sv

// File: hdl/dcache_pkg.sv
// shared cache types; geometry fixed at 4 words of 32 bits per line, only line_count varies
package dcache_pkg;

	// --------------------
	// geometry
	// --------------------
	localparam int word_w = 32;
	localparam int words_per_line = 4;
	localparam int word_addr_w = 30; // processor addresses words, not bytes

	localparam int offset_w = $clog2(words_per_line);
	localparam int block_addr_w = word_addr_w - offset_w; // line address on memory port
	localparam int line_w = word_w * words_per_line;

	// --------------------
	// basic types
	// --------------------
	typedef logic [word_w-1:0] word_t;

	// low offset_w bits pick the word, the rest is the line address
	typedef logic [word_addr_w-1:0] word_addr_t;

	typedef logic [block_addr_w-1:0] block_addr_t;

	// one line seen two ways
	// block for memory transfers, words for processor access and merges
	typedef union packed {
		logic [line_w-1:0] block;
		word_t [words_per_line-1:0] words; // words[0] is the lowest address
	} cache_line_u;

	// --------------------
	// request bundles
	// --------------------
	typedef struct packed {
		logic read;
		logic write;
		word_addr_t addr;
		word_t wdata;
	} proc_req_t;

	// at most one of read/write is set
	typedef struct packed {
		logic read;
		logic write;
		block_addr_t addr;
		cache_line_u wdata; // victim line, only meaningful with write
	} mem_req_t;

	// --------------------
	// controller states
	// --------------------
	typedef enum logic [1:0] {
		idle = 2'd0, // one cycle after reset
		compare_tag = 2'd1, // normal state, hits finish here
		write_back = 2'd2, // dirty victim out to memory
		allocate = 2'd3 // fetch requested line
	} ctrl_state_e;

endpackage

// File: hdl/dcache_top.sv
// cache top; line_count must be a power of two >= 2 and the processor holds proc_req while stalled
`timescale 1ns/1ps

module dcache_top #(
	parameter int line_count = 8
) (
	input logic clk,
	input logic proc_reset,

	// processor side
	input dcache_pkg::proc_req_t proc_req,
	output dcache_pkg::word_t proc_rdata,
	output logic proc_stall,

	// memory side
	output dcache_pkg::mem_req_t mem_req,
	input dcache_pkg::cache_line_u mem_rdata,
	input logic mem_ready
);

	localparam int index_w = $clog2(line_count);
	localparam int tag_w = dcache_pkg::block_addr_w - index_w;

	// --------------------
	// store <-> controller
	// --------------------
	logic [index_w-1:0] index;

	logic rd_valid;
	logic rd_dirty;
	logic [tag_w-1:0] rd_tag;
	dcache_pkg::cache_line_u rd_line;

	logic wr_en;
	logic wr_valid;
	logic wr_dirty;
	logic [tag_w-1:0] wr_tag;
	dcache_pkg::cache_line_u wr_line;

	line_store #(
		.line_count (line_count)
	) store_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.index      (index),
		.rd_valid   (rd_valid),
		.rd_dirty   (rd_dirty),
		.rd_tag     (rd_tag),
		.rd_line    (rd_line),
		.wr_en      (wr_en),
		.wr_valid   (wr_valid),
		.wr_dirty   (wr_dirty),
		.wr_tag     (wr_tag),
		.wr_line    (wr_line)
	);

	miss_controller #(
		.line_count (line_count)
	) ctrl_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.index      (index),
		.rd_valid   (rd_valid),
		.rd_dirty   (rd_dirty),
		.rd_tag     (rd_tag),
		.rd_line    (rd_line),
		.wr_en      (wr_en),
		.wr_valid   (wr_valid),
		.wr_dirty   (wr_dirty),
		.wr_tag     (wr_tag),
		.wr_line    (wr_line)
	);

endmodule

// File: hdl/line_store.sv
// per-line valid/dirty/tag/data; lookup is combinational, one whole-entry write per clock
`timescale 1ns/1ps

module line_store #(
	parameter int line_count = 8,
	localparam int index_w = $clog2(line_count),
	localparam int tag_w = dcache_pkg::block_addr_w - index_w
) (
	input logic clk,
	input logic proc_reset,

	// lookup
	input logic [index_w-1:0] index,
	output logic rd_valid,
	output logic rd_dirty,
	output logic [tag_w-1:0] rd_tag,
	output dcache_pkg::cache_line_u rd_line,

	// write port, replaces the indexed entry
	input logic wr_en,
	input logic wr_valid,
	input logic wr_dirty,
	input logic [tag_w-1:0] wr_tag,
	input dcache_pkg::cache_line_u wr_line
);

	// --------------------
	// storage
	// --------------------
	logic [line_count-1:0] valid_q; // one bit per line
	logic [line_count-1:0] dirty_q;
	logic [tag_w-1:0] tag_q [line_count];
	dcache_pkg::cache_line_u data_q [line_count];

	// status bits, cleared so every line starts invalid and clean
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (wr_en) begin
			valid_q[index] <= wr_valid;
			dirty_q[index] <= wr_dirty;
		end
	end

	// tag and payload
	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_q[index] <= wr_tag;
			data_q[index] <= wr_line;
		end
	end

	// --------------------
	// lookup
	// --------------------
	always_comb begin
		rd_valid = valid_q[index];
		rd_dirty = dirty_q[index];
		rd_tag = tag_q[index];
		rd_line = data_q[index];
	end

	// controller must sit in idle while reset is applied
	a_no_write_in_reset: assert property (@(posedge clk) proc_reset |-> !wr_en)
		else $error("line store written during reset");

endmodule

// File: hdl/miss_controller.sv
// cache FSM; one request at a time, processor holds proc_req until proc_stall is low
`timescale 1ns/1ps

module miss_controller #(
	parameter int line_count = 8,
	localparam int index_w = $clog2(line_count),
	localparam int tag_w = dcache_pkg::block_addr_w - index_w
) (
	input logic clk,
	input logic proc_reset,

	// processor side
	input dcache_pkg::proc_req_t proc_req,
	output dcache_pkg::word_t proc_rdata,
	output logic proc_stall,

	// memory side
	output dcache_pkg::mem_req_t mem_req,
	input dcache_pkg::cache_line_u mem_rdata,
	input logic mem_ready,

	// line store lookup
	output logic [index_w-1:0] index,
	input logic rd_valid,
	input logic rd_dirty,
	input logic [tag_w-1:0] rd_tag,
	input dcache_pkg::cache_line_u rd_line,

	// line store write port
	output logic wr_en,
	output logic wr_valid,
	output logic wr_dirty,
	output logic [tag_w-1:0] wr_tag,
	output dcache_pkg::cache_line_u wr_line
);

	// --------------------
	// address split
	// --------------------
	logic [dcache_pkg::offset_w-1:0] req_offset;
	logic [index_w-1:0] req_index;
	logic [tag_w-1:0] req_tag;
	dcache_pkg::block_addr_t req_block;
	dcache_pkg::block_addr_t victim_block;

	assign req_offset = proc_req.addr[dcache_pkg::offset_w-1:0];
	assign req_index = proc_req.addr[dcache_pkg::offset_w +: index_w];
	assign req_tag = proc_req.addr[dcache_pkg::word_addr_w-1 -: tag_w];
	assign req_block = proc_req.addr[dcache_pkg::word_addr_w-1:dcache_pkg::offset_w];

	// old line lives at its own tag plus the shared index
	assign victim_block = {rd_tag, req_index};

	assign index = req_index;

	logic req_active;
	logic hit;

	assign req_active = proc_req.read || proc_req.write;
	assign hit = rd_valid && (rd_tag == req_tag);

	// write data merged into the current line through the word view
	dcache_pkg::cache_line_u merged_line;

	always_comb begin
		merged_line = rd_line;
		merged_line.words[req_offset] = proc_req.wdata;
	end

	// --------------------
	// state register
	// --------------------
	dcache_pkg::ctrl_state_e state_q;
	dcache_pkg::ctrl_state_e state_d;

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= dcache_pkg::idle;
		end else begin
			state_q <= state_d;
		end
	end

	// --------------------
	// next state and outputs
	// --------------------
	always_comb begin
		state_d = state_q;
		proc_stall = 1'b1; // low only when a request can finish now
		proc_rdata = '0;

		mem_req.read = 1'b0;
		mem_req.write = 1'b0;
		mem_req.addr = req_block;
		mem_req.wdata = rd_line; // only looked at during write_back

		wr_en = 1'b0;
		wr_valid = 1'b1;
		wr_dirty = 1'b0;
		wr_tag = req_tag;
		wr_line = rd_line;

		case (state_q)
			dcache_pkg::idle: begin
				state_d = dcache_pkg::compare_tag;
			end

			dcache_pkg::compare_tag: begin
				if (req_active && !hit) begin
					// only a valid dirty victim needs to go out first
					if (rd_valid && rd_dirty) begin
						state_d = dcache_pkg::write_back;
					end else begin
						state_d = dcache_pkg::allocate;
					end
				end else begin
					proc_stall = 1'b0;
					if (proc_req.read) begin
						proc_rdata = rd_line.words[req_offset];
					end
					if (proc_req.write) begin
						wr_en = 1'b1;
						wr_dirty = 1'b1; // line now differs from memory
						wr_line = merged_line;
					end
				end
			end

			dcache_pkg::write_back: begin
				mem_req.write = 1'b1;
				mem_req.addr = victim_block;
				if (mem_ready) begin
					state_d = dcache_pkg::allocate;
				end
			end

			dcache_pkg::allocate: begin
				mem_req.read = 1'b1;
				if (mem_ready) begin
					// fill clean under the new tag, request hits next cycle
					wr_en = 1'b1;
					wr_line = mem_rdata;
					state_d = dcache_pkg::compare_tag;
				end
			end

			default: begin
				state_d = dcache_pkg::idle;
			end
		endcase
	end

	// --------------------
	// memory port checks
	// --------------------
	a_mem_one_cmd: assert property (@(posedge clk) !(mem_req.read && mem_req.write))
		else $error("memory read and write raised together");

	// address held until memory answers
	a_mem_addr_stable: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req.addr))
		else $error("memory address changed while waiting for mem_ready");

endmodule

// File: tests/dcache_tb.sv
// directed tests for dcache_top; the memory model only covers line addresses 0 to 63
`timescale 1ns/1ps

module dcache_tb;

	localparam int line_count = 8;
	localparam int mem_lines = 64;
	localparam int mem_latency = 3;
	localparam int stall_limit = 50; // cycles, covers write-back plus allocate
	localparam logic [31:0] rand_seed = 32'h79703bae;

	logic clk;
	logic proc_reset;
	dcache_pkg::proc_req_t proc_req;
	dcache_pkg::word_t proc_rdata;
	logic proc_stall;
	dcache_pkg::mem_req_t mem_req;
	dcache_pkg::cache_line_u mem_rdata;
	logic mem_ready;

	// shadow of line contents and of what the cache holds
	dcache_pkg::cache_line_u shadow_line [mem_lines];
	logic shadow_valid [line_count];
	logic shadow_dirty [line_count];
	int shadow_block [line_count];

	// memory traffic during the current access
	int rd_seen;
	int wr_seen;
	int rd_addr;
	int wr_addr;
	dcache_pkg::cache_line_u wr_data;

	dcache_top #(
		.line_count (line_count)
	) dut_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	slow_mem_model #(
		.latency (mem_latency),
		.depth   (mem_lines)
	) mem_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------
	function automatic dcache_pkg::word_t rule_word(input int b, input int k);
		return ((b << 4) | k) ^ 32'h5a5a0000;
	endfunction

	task automatic stop_with_error(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string test_name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (actual !== expected) begin
			stop_with_error($sformatf("MISMATCH %s expected %0h actual %0h",
				test_name, expected, actual));
		end
	endtask

	task automatic wait_unstalled(input string test_name, output int waited);
		waited = 0;
		@(negedge clk);
		while (proc_stall) begin
			waited++;
			if (waited > stall_limit) begin
				stop_with_error($sformatf("%s: proc_stall still high after %0d cycles",
					test_name, waited));
			end
			@(negedge clk);
		end
	endtask

	// memory monitor, samples mid-cycle
	always @(negedge clk) begin
		if (proc_reset && (mem_req.read || mem_req.write)) begin
			stop_with_error("memory request raised during reset");
		end
		if (!proc_reset && mem_ready && mem_req.write) begin
			if (rd_seen != 0) begin
				stop_with_error("memory write came after the allocate read");
			end
			wr_seen++;
			wr_addr = mem_req.addr;
			wr_data = mem_req.wdata;
		end
		if (!proc_reset && mem_ready && mem_req.read) begin
			rd_seen++;
			rd_addr = mem_req.addr;
		end
	end

	// one processor access, predicted from the shadow cache
	task automatic do_access(input string test_name, input logic is_write, input int block,
			input int word, input dcache_pkg::word_t wdata);
		int idx;
		int victim;
		int waited;
		logic exp_hit;
		logic exp_wb;
		idx = block % line_count;
		victim = shadow_block[idx];
		exp_hit = shadow_valid[idx] && (victim == block);
		exp_wb = !exp_hit && shadow_valid[idx] && shadow_dirty[idx];
		@(posedge clk);
		#5;
		rd_seen = 0;
		wr_seen = 0;
		proc_req.read = !is_write;
		proc_req.write = is_write;
		proc_req.addr = dcache_pkg::word_addr_t'(block * 4 + word);
		proc_req.wdata = wdata;
		wait_unstalled(test_name, waited);
		if (exp_hit) begin
			check_value(test_name, 0, waited); // hits add no cycles
		end else begin
			check_value(test_name, block, rd_addr);
		end
		check_value(test_name, exp_hit ? 0 : 1, rd_seen);
		check_value(test_name, exp_wb ? 1 : 0, wr_seen);
		if (exp_wb) begin
			check_value(test_name, victim, wr_addr);
			check_value(test_name, shadow_line[victim], wr_data);
		end
		if (!is_write) begin
			check_value(test_name, shadow_line[block].words[word], proc_rdata);
		end
		if (is_write) begin
			shadow_line[block].words[word] = wdata;
		end
		if (!exp_hit) begin
			shadow_valid[idx] = 1'b1;
			shadow_block[idx] = block;
			shadow_dirty[idx] = 1'b0;
		end
		shadow_dirty[idx] = shadow_dirty[idx] || is_write;
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic reset_sequence();
		int waited;
		proc_reset = 1'b1;
		repeat (10) begin
			@(posedge clk);
		end
		#5;
		proc_reset = 1'b0;
		wait_unstalled("reset", waited);
		check_value("reset", 1, waited); // one idle cycle before compare_tag
		check_value("reset", 2'b00, {mem_req.read, mem_req.write});
	endtask

	task automatic read_miss_then_hit();
		do_access("read miss", 1'b0, 1, 2, '0);
		do_access("read hit", 1'b0, 1, 3, '0);
	endtask

	task automatic write_hit_then_conflict();
		do_access("write hit", 1'b1, 1, 0, 32'hcafe0001);
		do_access("conflict read", 1'b0, 9, 1, '0); // same index, evicts dirty line 1
	endtask

	task automatic write_miss_then_evict();
		do_access("write miss", 1'b1, 20, 3, 32'h0badf00d);
		do_access("read after write miss", 1'b0, 20, 3, '0);
		do_access("evict written line", 1'b0, 28, 0, '0);
	endtask

	task automatic random_mix();
		int block;
		int word;
		logic is_write;
		dcache_pkg::word_t data;
		for (int n = 0; n < 200; n++) begin
			block = $urandom_range(mem_lines - 1, 0);
			word = $urandom_range(3, 0);
			is_write = $urandom_range(1, 0);
			data = $urandom;
			do_access($sformatf("random %0d", n), is_write, block, word, data);
		end
	endtask

	initial begin
		proc_reset = 1'b1;
		proc_req = '0;
		rd_seen = 0;
		wr_seen = 0;
		void'($urandom(rand_seed));
		for (int b = 0; b < mem_lines; b++) begin
			for (int k = 0; k < dcache_pkg::words_per_line; k++) begin
				shadow_line[b].words[k] = rule_word(b, k);
			end
		end
		for (int i = 0; i < line_count; i++) begin
			shadow_valid[i] = 1'b0;
			shadow_dirty[i] = 1'b0;
			shadow_block[i] = 0;
		end

		reset_sequence();
		read_miss_then_hit();
		write_hit_then_conflict();
		write_miss_then_evict();
		random_mix();

		@(posedge clk);
		#5;
		proc_req = '0;
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: tests/slow_mem_model.sv
// line-wide memory with fixed latency; only low address bits index it, keep line addresses below depth
`timescale 1ns/1ps

module slow_mem_model #(
	parameter int latency = 3,
	parameter int depth = 64
) (
	input logic clk,
	input logic proc_reset,
	input dcache_pkg::mem_req_t mem_req,
	output dcache_pkg::cache_line_u mem_rdata,
	output logic mem_ready
);

	localparam int slot_w = $clog2(depth);

	dcache_pkg::cache_line_u lines [depth];
	logic [slot_w-1:0] slot;
	int unsigned wait_count;
	logic ready_q;

	// word k of line b, spread over the whole line address
	function automatic dcache_pkg::word_t initial_word(input int b, input int k);
		return ((b << 4) | k) ^ 32'h5a5a0000;
	endfunction

	assign slot = mem_req.addr[slot_w-1:0];
	assign mem_rdata = lines[slot]; // only looked at while mem_ready is high
	assign mem_ready = ready_q;

	initial begin
		ready_q = 1'b0;
		wait_count = 0;
		for (int b = 0; b < depth; b++) begin
			for (int k = 0; k < dcache_pkg::words_per_line; k++) begin
				lines[b].words[k] = initial_word(b, k);
			end
		end
	end

	// --------------------
	// latency counter
	// --------------------
	always @(posedge clk) begin
		if (proc_reset) begin
			ready_q <= 1'b0;
			wait_count <= 0;
		end else begin
			ready_q <= 1'b0; // single-cycle pulse
			// a request still high during the pulse is the old one, skip it
			if ((mem_req.read || mem_req.write) && !ready_q) begin
				if (wait_count == latency - 1) begin
					ready_q <= 1'b1;
					wait_count <= 0;
					if (mem_req.write) begin
						lines[slot] <= mem_req.wdata;
					end
				end else begin
					wait_count <= wait_count + 1;
				end
			end
		end
	end

endmodule
